// File: verilog/ecc_pkg.sv
package ecc_pkg;

  typedef enum logic [1:0] {
    ECC_NONE,
    ECC_PARITY,
    ECC_SECDED
  } ecc_mode_e;

  localparam int DATA_WIDTH = 32;
  localparam int ECC_WIDTH  = 7;  // 6 hamming bits plus overall parity.
  localparam int ADDR_WIDTH = 4;
  localparam int PADR_WIDTH = 2;

  function automatic int ecc_mem_width(ecc_mode_e mode, int data_width, int ecc_width);
    case (mode)
      ECC_PARITY: return data_width + 1;
      ECC_SECDED: return data_width + ecc_width;
      default:    return data_width;
    endcase
  endfunction

  // hamming position of data bit idx, counting from 1 and skipping powers of two
  function automatic int unsigned ecc_data_pos(int unsigned idx);
    int unsigned cnt;
    int unsigned pos;
    cnt = 0;
    pos = 0;
    for (int unsigned p = 3; p < idx + 40; p++) begin
      if ((p & (p - 1)) != 0 && pos == 0) begin
        if (cnt == idx) begin
          pos = p;
        end
        cnt++;
      end
    end
    return pos;
  endfunction

endpackage

// File: verilog/ecc_encode.sv
`timescale 1ns/1ps

module ecc_encode #(
  parameter ecc_pkg::ecc_mode_e mode = ecc_pkg::ECC_SECDED,
  parameter int data_width = ecc_pkg::DATA_WIDTH,
  parameter int ecc_width  = ecc_pkg::ECC_WIDTH,
  parameter int mem_width  = ecc_pkg::ecc_mem_width(mode, data_width, ecc_width)
) (
  input  logic [data_width-1:0] din,
  output logic [mem_width-1:0]  code
);
  import ecc_pkg::*;

  if (mode == ECC_SECDED) begin : g_secded
    localparam int ham_width = ecc_width - 1;

    logic [ham_width-1:0] pos_tab [data_width];
    logic [ham_width-1:0] ham;

    for (genvar j = 0; j < data_width; j++) begin : g_pos
      localparam int unsigned pos = ecc_data_pos(j);
      assign pos_tab[j] = ham_width'(pos);
    end

    always_comb begin
      ham = '0;
      for (int i = 0; i < ham_width; i++) begin
        for (int j = 0; j < data_width; j++) begin
          if (pos_tab[j][i]) begin
            ham[i] = ham[i] ^ din[j];
          end
        end
      end
    end

    // top bit evens out the whole codeword.
    assign code = {^{ham, din}, ham, din};

  end else if (mode == ECC_PARITY) begin : g_parity

    assign code = {^din, din};  // stored word xors to zero.

  end else begin : g_none

    assign code = din;

  end

endmodule

// File: verilog/ecc_check.sv
`timescale 1ns/1ps

module ecc_check #(
  parameter int data_width = ecc_pkg::DATA_WIDTH,
  parameter int ecc_width  = ecc_pkg::ECC_WIDTH,
  parameter int flop_ecc1  = 0,
  parameter int flop_ecc2  = 0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [data_width-1:0] din,
  input  logic [ecc_width-1:0]  eccin,
  output logic [data_width-1:0] dout,
  output logic                  sec_err,
  output logic                  ded_err
);
  import ecc_pkg::*;

  localparam int ham_width = ecc_width - 1;

  logic [ham_width-1:0]  pos_tab [data_width];
  logic [ham_width-1:0]  syn_c;
  logic                  perr_c;
  logic [data_width-1:0] din_s;
  logic [ham_width-1:0]  syn_s;
  logic                  perr_s;
  logic [data_width-1:0] dout_c;
  logic                  sec_c;
  logic                  ded_c;

  for (genvar j = 0; j < data_width; j++) begin : g_pos
    localparam int unsigned pos = ecc_data_pos(j);
    assign pos_tab[j] = ham_width'(pos);
  end

  always_comb begin
    syn_c = eccin[ham_width-1:0];
    for (int i = 0; i < ham_width; i++) begin
      for (int j = 0; j < data_width; j++) begin
        if (pos_tab[j][i]) begin
          syn_c[i] = syn_c[i] ^ din[j];
        end
      end
    end
  end

  assign perr_c = ^{eccin, din};  // odd weight means one bit flipped.

  if (flop_ecc1 != 0) begin : g_flop1
    always_ff @(posedge clk) begin
      din_s <= din;
      syn_s <= syn_c;
    end
    always_ff @(posedge clk) begin
      if (reset) begin
        perr_s <= 1'b0;
      end else begin
        perr_s <= perr_c;
      end
    end
  end else begin : g_comb1
    assign din_s  = din;
    assign syn_s  = syn_c;
    assign perr_s = perr_c;
  end

  // syndrome names the flipped position; check bit positions match no data bit
  always_comb begin
    dout_c = din_s;
    for (int j = 0; j < data_width; j++) begin
      if (perr_s && syn_s == pos_tab[j]) begin
        dout_c[j] = ~din_s[j];
      end
    end
  end

  assign sec_c = perr_s;
  assign ded_c = !perr_s && syn_s != '0;  // even weight with nonzero syndrome.

  if (flop_ecc2 != 0) begin : g_flop2
    always_ff @(posedge clk) begin
      dout <= dout_c;
    end
    always_ff @(posedge clk) begin
      if (reset) begin
        sec_err <= 1'b0;
        ded_err <= 1'b0;
      end else begin
        sec_err <= sec_c;
        ded_err <= ded_c;
      end
    end
  end else begin : g_comb2
    assign dout    = dout_c;
    assign sec_err = sec_c;
    assign ded_err = ded_c;
  end

endmodule

// File: verilog/core_ecc_check.sv
`timescale 1ns/1ps

module core_ecc_check #(
  parameter ecc_pkg::ecc_mode_e mode = ecc_pkg::ECC_SECDED,
  parameter int data_width = ecc_pkg::DATA_WIDTH,
  parameter int ecc_width  = ecc_pkg::ECC_WIDTH,
  parameter int mem_width  = ecc_pkg::ecc_mem_width(mode, data_width, ecc_width),
  parameter int padr_width = ecc_pkg::PADR_WIDTH,
  parameter int flop_ecc1  = 0,
  parameter int flop_ecc2  = 0
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [mem_width-1:0]  mem_rd_dout,
  input  logic                  mem_rd_vld,
  input  logic                  mem_rd_fwrd,
  input  logic [padr_width-1:0] mem_rd_padr,
  output logic [data_width-1:0] rd_dout,
  output logic                  rd_vld,
  output logic                  rd_serr,
  output logic                  rd_derr,
  output logic                  rd_fwrd,
  output logic [padr_width-1:0] rd_padr
);
  import ecc_pkg::*;

  localparam int ecc_delay = (mode == ECC_NONE) ? 0 :
                             (flop_ecc1 != 0 ? 1 : 0) + (flop_ecc2 != 0 ? 1 : 0);
  // parity result rides the sideband pipe; secded data is delayed in ecc_check.
  localparam int side_w = 1 + padr_width + ((mode == ECC_PARITY) ? data_width + 1 : 0);

  logic              side_vld;
  logic [side_w-1:0] side_in;
  logic [side_w-1:0] side_out;

  if (ecc_delay > 0) begin : g_delay
    logic              vld_q  [ecc_delay];
    logic [side_w-1:0] side_q [ecc_delay];

    always_ff @(posedge clk) begin
      if (reset) begin
        for (int s = 0; s < ecc_delay; s++) begin
          vld_q[s] <= 1'b0;
        end
      end else begin
        vld_q[0] <= mem_rd_vld;
        for (int s = 1; s < ecc_delay; s++) begin
          vld_q[s] <= vld_q[s-1];
        end
      end
    end

    always_ff @(posedge clk) begin
      side_q[0] <= side_in;
      for (int s = 1; s < ecc_delay; s++) begin
        side_q[s] <= side_q[s-1];
      end
    end

    assign side_vld = vld_q[ecc_delay-1];
    assign side_out = side_q[ecc_delay-1];
  end else begin : g_nodelay
    assign side_vld = mem_rd_vld;
    assign side_out = side_in;
  end

  assign rd_vld = side_vld;

  if (mode == ECC_SECDED) begin : g_secded
    assign side_in = {mem_rd_fwrd, mem_rd_padr};
    assign {rd_fwrd, rd_padr} = side_out;

    ecc_check #(
      .data_width(data_width),
      .ecc_width (ecc_width),
      .flop_ecc1 (flop_ecc1),
      .flop_ecc2 (flop_ecc2)
    ) ecc_check_i (
      .clk    (clk),
      .reset  (reset),
      .din    (mem_rd_dout[data_width-1:0]),
      .eccin  (mem_rd_dout[data_width +: ecc_width]),
      .dout   (rd_dout),
      .sec_err(rd_serr),
      .ded_err(rd_derr)
    );
  end else if (mode == ECC_PARITY) begin : g_parity
    assign side_in = {mem_rd_fwrd, mem_rd_padr, ^mem_rd_dout, mem_rd_dout[data_width-1:0]};
    assign {rd_fwrd, rd_padr, rd_serr, rd_dout} = side_out;
    assign rd_derr = 1'b0;  // parity cannot tell one flip from three.
  end else begin : g_none
    assign side_in = {mem_rd_fwrd, mem_rd_padr};
    assign {rd_fwrd, rd_padr} = side_out;
    assign rd_dout = mem_rd_dout[data_width-1:0];
    assign rd_serr = 1'b0;
    assign rd_derr = 1'b0;
  end

endmodule

// File: verilog/ecc_ram.sv
`timescale 1ns/1ps

module ecc_ram #(
  parameter int mem_width  = ecc_pkg::ecc_mem_width(ecc_pkg::ECC_SECDED,
                                                    ecc_pkg::DATA_WIDTH,
                                                    ecc_pkg::ECC_WIDTH),
  parameter int addr_width = ecc_pkg::ADDR_WIDTH,
  parameter int padr_width = ecc_pkg::PADR_WIDTH
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wr_vld,
  input  logic [addr_width-1:0] wr_adr,
  input  logic [mem_width-1:0]  wr_code,
  input  logic [mem_width-1:0]  wr_flip,
  input  logic                  rd_req,
  input  logic [addr_width-1:0] rd_adr,
  input  logic                  rd_req_fwrd,
  input  logic [padr_width-1:0] rd_req_padr,
  output logic [mem_width-1:0]  mem_rd_dout,
  output logic                  mem_rd_vld,
  output logic                  mem_rd_fwrd,
  output logic [padr_width-1:0] mem_rd_padr
);

  localparam int depth = 1 << addr_width;

  logic [mem_width-1:0] mem [depth];

  // flip mask lets errors be planted on purpose.
  always_ff @(posedge clk) begin
    if (wr_vld) begin
      mem[wr_adr] <= wr_code ^ wr_flip;
    end
  end

  // read samples the array before this edge's write lands.
  always_ff @(posedge clk) begin
    if (rd_req) begin
      mem_rd_dout <= mem[rd_adr];
      mem_rd_fwrd <= rd_req_fwrd;
      mem_rd_padr <= rd_req_padr;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_rd_vld <= 1'b0;
    end else begin
      mem_rd_vld <= rd_req;
    end
  end

endmodule

// File: verilog/ecc_mem_top.sv
`timescale 1ns/1ps

module ecc_mem_top #(
  parameter ecc_pkg::ecc_mode_e mode = ecc_pkg::ECC_SECDED,
  parameter int data_width = ecc_pkg::DATA_WIDTH,
  parameter int ecc_width  = ecc_pkg::ECC_WIDTH,
  parameter int addr_width = ecc_pkg::ADDR_WIDTH,
  parameter int padr_width = ecc_pkg::PADR_WIDTH,
  parameter int flop_ecc1  = 0,
  parameter int flop_ecc2  = 0,
  localparam int mem_width = ecc_pkg::ecc_mem_width(mode, data_width, ecc_width)
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  wr_vld,
  input  logic [addr_width-1:0] wr_adr,
  input  logic [data_width-1:0] wr_din,
  input  logic [mem_width-1:0]  wr_flip,
  input  logic                  rd_req,
  input  logic [addr_width-1:0] rd_adr,
  input  logic                  rd_req_fwrd,
  input  logic [padr_width-1:0] rd_req_padr,
  output logic [data_width-1:0] rd_dout,
  output logic                  rd_vld,
  output logic                  rd_serr,
  output logic                  rd_derr,
  output logic                  rd_fwrd,
  output logic [padr_width-1:0] rd_padr
);

  logic [mem_width-1:0]  wr_code;
  logic [mem_width-1:0]  mem_rd_dout;
  logic                  mem_rd_vld;
  logic                  mem_rd_fwrd;
  logic [padr_width-1:0] mem_rd_padr;

  ecc_encode #(
    .mode      (mode),
    .data_width(data_width),
    .ecc_width (ecc_width),
    .mem_width (mem_width)
  ) encode_i (
    .din (wr_din),
    .code(wr_code)
  );

  ecc_ram #(
    .mem_width (mem_width),
    .addr_width(addr_width),
    .padr_width(padr_width)
  ) ram_i (
    .clk        (clk),
    .reset      (reset),
    .wr_vld     (wr_vld),
    .wr_adr     (wr_adr),
    .wr_code    (wr_code),
    .wr_flip    (wr_flip),
    .rd_req     (rd_req),
    .rd_adr     (rd_adr),
    .rd_req_fwrd(rd_req_fwrd),
    .rd_req_padr(rd_req_padr),
    .mem_rd_dout(mem_rd_dout),
    .mem_rd_vld (mem_rd_vld),
    .mem_rd_fwrd(mem_rd_fwrd),
    .mem_rd_padr(mem_rd_padr)
  );

  core_ecc_check #(
    .mode      (mode),
    .data_width(data_width),
    .ecc_width (ecc_width),
    .mem_width (mem_width),
    .padr_width(padr_width),
    .flop_ecc1 (flop_ecc1),
    .flop_ecc2 (flop_ecc2)
  ) check_i (
    .clk        (clk),
    .reset      (reset),
    .mem_rd_dout(mem_rd_dout),
    .mem_rd_vld (mem_rd_vld),
    .mem_rd_fwrd(mem_rd_fwrd),
    .mem_rd_padr(mem_rd_padr),
    .rd_dout    (rd_dout),
    .rd_vld     (rd_vld),
    .rd_serr    (rd_serr),
    .rd_derr    (rd_derr),
    .rd_fwrd    (rd_fwrd),
    .rd_padr    (rd_padr)
  );

endmodule

// File: sim/ecc_mem_tb.sv
`timescale 1ns/1ps

module ecc_mem_tb;
  import ecc_pkg::*;

  localparam int clk_period   = 4;
  localparam int reset_cycles = 8;
  localparam int flop1        = 1;
  localparam int flop2        = 0;
  localparam int rd_latency   = 1 + flop1 + flop2;
  localparam int mem_width    = ecc_mem_width(ECC_SECDED, DATA_WIDTH, ECC_WIDTH);
  localparam int words        = 1 << ADDR_WIDTH;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_WRITE_READ
  } op_e;

  typedef struct packed {
    op_e                   op;
    logic [ADDR_WIDTH-1:0] adr;
    logic [DATA_WIDTH-1:0] data;
    logic [mem_width-1:0]  flip;
    logic [DATA_WIDTH-1:0] exp_data;
    logic                  exp_serr;
    logic                  exp_derr;
    logic                  chk_data;
  } entry_t;

  typedef struct packed {
    int                    idx;
    logic [PADR_WIDTH-1:0] padr;
    logic                  fwrd;
    int                    cyc;
  } pend_t;

  logic                  clk;
  logic                  reset;
  logic                  wr_vld;
  logic [ADDR_WIDTH-1:0] wr_adr;
  logic [DATA_WIDTH-1:0] wr_din;
  logic [mem_width-1:0]  wr_flip;
  logic                  rd_req;
  logic [ADDR_WIDTH-1:0] rd_adr;
  logic                  rd_req_fwrd;
  logic [PADR_WIDTH-1:0] rd_req_padr;
  logic [DATA_WIDTH-1:0] rd_dout;
  logic                  rd_vld;
  logic                  rd_serr;
  logic                  rd_derr;
  logic                  rd_fwrd;
  logic [PADR_WIDTH-1:0] rd_padr;

  entry_t tab[$];
  string  tab_name[$];
  pend_t  pend_q[$];
  int     err_cnt = 0;
  int     check_cnt = 0;
  int     rd_issued = 0;
  int     rd_seen = 0;
  int     cycle_cnt = 0;
  logic   table_ready = 1'b0;

  ecc_mem_top #(
    .mode      (ECC_SECDED),
    .data_width(DATA_WIDTH),
    .ecc_width (ECC_WIDTH),
    .addr_width(ADDR_WIDTH),
    .padr_width(PADR_WIDTH),
    .flop_ecc1 (flop1),
    .flop_ecc2 (flop2)
  ) dut_i (
    .clk        (clk),
    .reset      (reset),
    .wr_vld     (wr_vld),
    .wr_adr     (wr_adr),
    .wr_din     (wr_din),
    .wr_flip    (wr_flip),
    .rd_req     (rd_req),
    .rd_adr     (rd_adr),
    .rd_req_fwrd(rd_req_fwrd),
    .rd_req_padr(rd_req_padr),
    .rd_dout    (rd_dout),
    .rd_vld     (rd_vld),
    .rd_serr    (rd_serr),
    .rd_derr    (rd_derr),
    .rd_fwrd    (rd_fwrd),
    .rd_padr    (rd_padr)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] exp_val,
                            input logic [DATA_WIDTH-1:0] act_val);
    check_cnt++;
    if (act_val !== exp_val) begin
      err_cnt++;
      $display("FAILED %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  task automatic check_flag(input string name, input logic exp_val, input logic act_val);
    check_cnt++;
    if (act_val !== exp_val) begin
      err_cnt++;
      $display("FAILED %s: expected %b, actual %b", name, exp_val, act_val);
    end
  endtask

  task automatic check_tag(input string name, input logic [PADR_WIDTH-1:0] exp_padr,
                           input logic exp_fwrd, input logic [PADR_WIDTH-1:0] act_padr,
                           input logic act_fwrd);
    check_cnt++;
    if ({act_fwrd, act_padr} !== {exp_fwrd, exp_padr}) begin
      err_cnt++;
      $display("FAILED %s tag: expected fwrd %b padr %h, actual fwrd %b padr %h",
               name, exp_fwrd, exp_padr, act_fwrd, act_padr);
    end
  endtask

  task automatic add_entry(input op_e op, input logic [ADDR_WIDTH-1:0] adr,
                           input logic [DATA_WIDTH-1:0] data, input logic [mem_width-1:0] flip,
                           input logic [DATA_WIDTH-1:0] exp_data, input logic exp_serr,
                           input logic exp_derr, input logic chk_data, input string name);
    entry_t e;
    e = '0;
    e.op = op;
    e.adr = adr;
    e.data = data;
    e.flip = flip;
    e.exp_data = exp_data;
    e.exp_serr = exp_serr;
    e.exp_derr = exp_derr;
    e.chk_data = chk_data;
    tab.push_back(e);
    tab_name.push_back(name);
  endtask

  task automatic build_table();
    logic [DATA_WIDTH-1:0] shadow [words];
    logic [DATA_WIDTH-1:0] d;
    logic [DATA_WIDTH-1:0] d_new;
    logic [ADDR_WIDTH-1:0] a;
    int                    b1;
    int                    b2;
    for (int i = 0; i < words; i++) begin
      shadow[i] = $urandom();
      add_entry(OP_WRITE, ADDR_WIDTH'(i), shadow[i], '0, '0, 1'b0, 1'b0, 1'b0,
                $sformatf("clean write %0d", i));
    end
    for (int i = 0; i < words; i++) begin  // back to back, tags wrap.
      add_entry(OP_READ, ADDR_WIDTH'(i), '0, '0, shadow[i], 1'b0, 1'b0, 1'b1,
                $sformatf("clean read %0d", i));
    end
    for (int k = 0; k < 8; k++) begin
      a = ADDR_WIDTH'(k);
      d = $urandom();
      b1 = int'($urandom() % DATA_WIDTH);
      add_entry(OP_WRITE, a, d, mem_width'(1) << b1, '0, 1'b0, 1'b0, 1'b0,
                $sformatf("data flip write bit %0d", b1));
      add_entry(OP_READ, a, '0, '0, d, 1'b1, 1'b0, 1'b1,
                $sformatf("data flip read bit %0d", b1));
    end
    for (int c = 0; c < ECC_WIDTH; c++) begin  // includes the overall parity bit.
      a = ADDR_WIDTH'(8 + c);
      d = $urandom();
      add_entry(OP_WRITE, a, d, mem_width'(1) << (DATA_WIDTH + c), '0, 1'b0, 1'b0, 1'b0,
                $sformatf("check flip write bit %0d", c));
      add_entry(OP_READ, a, '0, '0, d, 1'b1, 1'b0, 1'b1,
                $sformatf("check flip read bit %0d", c));
    end
    for (int k = 0; k < 6; k++) begin
      a = ADDR_WIDTH'(2 + k);
      d = $urandom();
      b1 = int'($urandom() % mem_width);
      b2 = (b1 + 1 + int'($urandom() % (mem_width - 1))) % mem_width;  // never equals b1.
      add_entry(OP_WRITE, a, d, (mem_width'(1) << b1) | (mem_width'(1) << b2), '0,
                1'b0, 1'b0, 1'b0, $sformatf("double flip write bits %0d %0d", b1, b2));
      add_entry(OP_READ, a, '0, '0, d, 1'b0, 1'b1, 1'b0,
                $sformatf("double flip read bits %0d %0d", b1, b2));
    end
    for (int k = 0; k < 4; k++) begin
      a = ADDR_WIDTH'(12 + k);
      d = $urandom();
      d_new = $urandom();
      add_entry(OP_WRITE, a, d, '0, '0, 1'b0, 1'b0, 1'b0, $sformatf("old word write %0d", k));
      add_entry(OP_WRITE_READ, a, d_new, '0, d, 1'b0, 1'b0, 1'b1,
                $sformatf("same cycle write read %0d", k));
      add_entry(OP_READ, a, '0, '0, d_new, 1'b0, 1'b0, 1'b1,
                $sformatf("new word read %0d", k));
    end
  endtask

  task automatic apply_entry(input int i);
    entry_t e;
    pend_t  p;
    e = tab[i];
    @(posedge clk);
    #1;
    wr_vld = 1'b0;
    wr_flip = '0;
    rd_req = 1'b0;
    if (e.op == OP_WRITE || e.op == OP_WRITE_READ) begin
      wr_vld = 1'b1;
      wr_adr = e.adr;
      wr_din = e.data;
      wr_flip = e.flip;
    end
    if (e.op == OP_READ || e.op == OP_WRITE_READ) begin
      rd_req = 1'b1;
      rd_adr = e.adr;
      rd_req_padr = rd_issued[PADR_WIDTH-1:0];
      rd_req_fwrd = rd_issued[PADR_WIDTH];
      p.idx = i;
      p.padr = rd_req_padr;
      p.fwrd = rd_req_fwrd;
      p.cyc = cycle_cnt;
      pend_q.push_back(p);
      rd_issued++;
    end
  endtask

  // outputs settle well before the falling edge.
  always @(negedge clk) begin : rd_monitor
    pend_t  p;
    entry_t e;
    if (reset) begin
      if (rd_vld !== 1'b0) begin
        err_cnt++;
        $display("rd_vld is not low during reset at %0t", $time);
      end
    end else if (rd_vld === 1'b1) begin
      if (pend_q.size() == 0) begin
        err_cnt++;
        $display("rd_vld seen with no read request outstanding at %0t", $time);
      end else begin
        p = pend_q.pop_front();
        e = tab[p.idx];
        rd_seen++;
        check_tag(tab_name[p.idx], p.padr, p.fwrd, rd_padr, rd_fwrd);
        if (cycle_cnt - p.cyc != rd_latency) begin
          err_cnt++;
          $display("%s returned after %0d cycles instead of %0d",
                   tab_name[p.idx], cycle_cnt - p.cyc, rd_latency);
        end
        if (e.chk_data) begin
          check_data(tab_name[p.idx], e.exp_data, rd_dout);
        end
        check_flag({tab_name[p.idx], " serr"}, e.exp_serr, rd_serr);
        check_flag({tab_name[p.idx], " derr"}, e.exp_derr, rd_derr);
      end
    end
  end

  initial begin : watchdog
    int limit_ns;
    wait (table_ready === 1'b1);
    limit_ns = tab.size() * 8 * clk_period + reset_cycles * clk_period;
    #(limit_ns);
    $display("timeout: run did not finish within %0d ns", limit_ns);
    $display("Simulation failed");
    $finish;
  end

  initial begin : main
    reset = 1'b1;
    wr_vld = 1'b0;
    wr_adr = '0;
    wr_din = '0;
    wr_flip = '0;
    rd_req = 1'b1;  // reads held during reset must not come back.
    rd_adr = '0;
    rd_req_fwrd = 1'b0;
    rd_req_padr = '0;
    void'($urandom(32'h49b3_bf6b));
    build_table();
    table_ready = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #1;
    reset = 1'b0;
    rd_req = 1'b0;
    foreach (tab[i]) begin
      apply_entry(i);
    end
    @(posedge clk);
    #1;
    wr_vld = 1'b0;
    wr_flip = '0;
    rd_req = 1'b0;
    wait (pend_q.size() == 0);
    repeat (4) @(posedge clk);  // quiet window to catch a stray rd_vld.
    $display("reads issued %0d, reads returned %0d, checks %0d, errors %0d",
             rd_issued, rd_seen, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
verilog/ecc_pkg.sv
verilog/ecc_encode.sv
verilog/ecc_check.sv
verilog/core_ecc_check.sv
verilog/ecc_ram.sv
verilog/ecc_mem_top.sv
sim/ecc_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the ECC memory testbench with Verilator, run it, and scan the log.

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

rm -rf obj_dir "$build_log" "$sim_log"

verilator --binary --timing -j 0 --top-module ecc_mem_tb -f vlog.f \
  -o ecc_mem_sim > "$build_log" 2>&1 \
  && ./obj_dir/ecc_mem_sim > "$sim_log" 2>&1 \
  || { cat "$build_log" "$sim_log" 2> /dev/null; echo "build or run error"; exit 1; }

cat "$sim_log"

grep -q "Simulation failed" "$sim_log" \
  && { echo "FAIL"; exit 1; } \
  || grep -q "Simulation completed successfully" "$sim_log" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL: no result line in $sim_log"; exit 1; }
